//--- design/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int BAUD_DIV      = 434;    // clocks per bit
  localparam int BIT_CNT_W     = 9;
  localparam int FRAME_GAP     = 16;     // idle clocks between write frames
  localparam int REPLY_TIMEOUT = 10416;  // 24 bit times
  localparam int TIMEOUT_W     = 14;

  // bit 15 set means write, high byte goes out first
  typedef logic [15:0] cmd_t;

  typedef logic [7:0] byte_t;

  typedef logic [BIT_CNT_W-1:0] baud_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SEND_HI,
    GAP,
    SEND_LO,
    WAIT_REPLY,
    REPORT
  } ctrl_state_t;

endpackage

//--- design/uart_byte_if.sv
`timescale 1ns/1ps

interface uart_byte_if;

  logic                start;  // one cycle, only while busy is low
  uart_cmd_pkg::byte_t data;   // held by controller for the whole frame
  logic                busy;
  logic                done;   // last cycle of stop bit

  modport ctrl (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport tx (
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic    clk,
  input  logic    rst_n,
  uart_byte_if.tx txb,
  output logic    tx
);

  logic [9:0]              shreg;     // stop, parity, data
  uart_cmd_pkg::baud_cnt_t baud_cnt;
  logic [3:0]              bit_idx;   // 0 start .. 10 stop
  logic                    bit_end;

  assign bit_end = (baud_cnt == uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV - 1));

  assign txb.done = txb.busy && bit_end && (bit_idx == 4'd10);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      txb.busy <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!txb.busy)
    begin
      baud_cnt <= '0;
      bit_idx  <= '0;
      if (txb.start)
      begin
        tx       <= 1'b0;  // start bit
        txb.busy <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        txb.busy <= 1'b0;  // line already idle high
      end
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // even parity makes the ones count over data+parity even
  always_ff @(posedge clk)
  begin
    if (!txb.busy && txb.start)
    begin
      shreg <= {1'b1, ^txb.data, txb.data};
    end
    else if (txb.busy && bit_end)
    begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output uart_cmd_pkg::byte_t rx_data,
  output logic                rx_valid,
  output logic                rx_perr,
  output logic                rx_busy
);

  logic [1:0]              rx_sync;
  logic                    rx_d;       // delayed synced line, edge detect
  uart_cmd_pkg::baud_cnt_t baud_cnt;
  uart_cmd_pkg::baud_cnt_t cnt_target;
  logic [3:0]              bit_idx;    // 0 start .. 10 stop
  logic                    sample;
  logic                    par_bit;
  uart_cmd_pkg::byte_t     shreg;

  // first target lands near start-bit center, after that one full bit
  assign cnt_target = (bit_idx == 4'd0) ?
                      uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV / 2 - 2) :
                      uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV - 1);

  assign sample  = rx_busy && (baud_cnt == cnt_target);
  assign rx_data = shreg;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync  <= 2'b11;
      rx_d     <= 1'b1;
      rx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
      rx_perr  <= 1'b0;
    end
    else
    begin
      rx_sync  <= {rx_sync[0], rx};
      rx_d     <= rx_sync[1];
      rx_valid <= 1'b0;
      if (!rx_busy)
      begin
        if (rx_d && !rx_sync[1])  // falling edge
        begin
          rx_busy  <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync[1])
        begin
          rx_busy <= 1'b0;  // glitch, drop it
        end
        else if (bit_idx == 4'd10)
        begin
          rx_busy  <= 1'b0;
          rx_valid <= 1'b1;
          rx_perr  <= (^{shreg, par_bit}) | !rx_sync[1];  // parity or framing
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
      begin
        shreg <= {rx_sync[1], shreg[7:1]};  // lsb first
      end
      if (bit_idx == 4'd9)
      begin
        par_bit <= rx_sync[1];
      end
    end
  end

endmodule

//--- design/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  uart_byte_if.ctrl           txb,
  input  uart_cmd_pkg::byte_t rx_data,
  input  logic                rx_valid,
  input  logic                rx_perr,
  input  logic                rx_busy,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_rdy,
  output logic                read_err
);

  typedef logic [uart_cmd_pkg::TIMEOUT_W-1:0] wait_cnt_t;

  uart_cmd_pkg::ctrl_state_t state;
  uart_cmd_pkg::ctrl_state_t state_nxt;
  uart_cmd_pkg::cmd_t        cmd_reg;
  wait_cnt_t                 wait_cnt;   // gap and reply timeout share it
  logic                      gap_end;
  logic                      reply_timeout;

  assign gap_end = (wait_cnt == wait_cnt_t'(uart_cmd_pkg::FRAME_GAP - 1));

  // the count is frozen while a reply frame is coming in
  assign reply_timeout = !rx_busy &&
                         (wait_cnt == wait_cnt_t'(uart_cmd_pkg::REPLY_TIMEOUT - 1));

  assign cmd_rdy  = (state == uart_cmd_pkg::IDLE);
  assign read_rdy = (state == uart_cmd_pkg::REPORT);

  assign txb.start = !txb.busy &&
                     ((state == uart_cmd_pkg::LOAD) ||
                      (state == uart_cmd_pkg::GAP && gap_end));
  assign txb.data  = (state == uart_cmd_pkg::GAP || state == uart_cmd_pkg::SEND_LO) ?
                     cmd_reg[7:0] : cmd_reg[15:8];

  always_comb
  begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::IDLE:
      begin
        if (cmd_vld)
          state_nxt = uart_cmd_pkg::LOAD;
      end
      uart_cmd_pkg::LOAD:
      begin
        state_nxt = uart_cmd_pkg::SEND_HI;
      end
      uart_cmd_pkg::SEND_HI:
      begin
        if (txb.done)
          state_nxt = cmd_reg[15] ? uart_cmd_pkg::GAP : uart_cmd_pkg::WAIT_REPLY;
      end
      uart_cmd_pkg::GAP:
      begin
        if (gap_end)
          state_nxt = uart_cmd_pkg::SEND_LO;
      end
      uart_cmd_pkg::SEND_LO:
      begin
        if (txb.done)
          state_nxt = uart_cmd_pkg::IDLE;
      end
      uart_cmd_pkg::WAIT_REPLY:
      begin
        if (rx_valid || reply_timeout)
          state_nxt = uart_cmd_pkg::REPORT;
      end
      default:
      begin
        state_nxt = uart_cmd_pkg::IDLE;  // REPORT lasts one cycle
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= uart_cmd_pkg::IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wait_cnt <= '0;
    else if (state_nxt != state)
      wait_cnt <= '0;
    else if (state == uart_cmd_pkg::GAP ||
             (state == uart_cmd_pkg::WAIT_REPLY && !rx_busy))
      wait_cnt <= wait_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (state == uart_cmd_pkg::IDLE && cmd_vld)
      cmd_reg <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else if (state == uart_cmd_pkg::WAIT_REPLY)
    begin
      if (rx_valid)
      begin
        read_data <= rx_data;
        read_err  <= rx_perr;
      end
      else if (reply_timeout)
      begin
        read_data <= '0;  // no reply
        read_err  <= 1'b1;
      end
    end
  end

endmodule

//--- design/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_rdy,
  output logic                read_err
);

  uart_cmd_pkg::byte_t rx_data;
  logic                rx_valid;
  logic                rx_perr;
  logic                rx_busy;

  uart_byte_if txb_if ();

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .txb       (txb_if.ctrl),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_perr   (rx_perr),
    .rx_busy   (rx_busy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .txb   (txb_if.tx),
    .tx    (tx)
  );

  uart_rx u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_perr  (rx_perr),
    .rx_busy  (rx_busy)
  );

endmodule

//--- tb/tb_uart_cmd_top.sv
`timescale 1ns/1ps

module tb_uart_cmd_top;

  localparam int BIT_CYC   = uart_cmd_pkg::BAUD_DIV;
  localparam int FRAME_CYC = 11 * BIT_CYC;

  logic                clk;
  logic                rst_n;
  uart_cmd_pkg::cmd_t  cmd_in;
  logic                cmd_vld;
  logic                cmd_rdy;
  logic                rx;
  logic                tx;
  uart_cmd_pkg::byte_t read_data;
  logic                read_rdy;
  logic                read_err;

  int errors;
  int checks;
  int seed;
  int cyc = 0;         // free running cycle count
  int rdy_pulses = 0;

  uart_cmd_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
      rdy_pulses++;
  end

  task automatic check_byte(input string name, input uart_cmd_pkg::byte_t got,
                            input uart_cmd_pkg::byte_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input string name, input uart_cmd_pkg::cmd_t got,
                           input uart_cmd_pkg::cmd_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  // returns at the middle of the stop bit
  task automatic recv_frame(output uart_cmd_pkg::byte_t data, output logic par,
                            output logic stop, output int fall_cyc);
    int waited;
    int i;
    waited = 0;
    data = '0;
    par = 1'b0;
    stop = 1'b0;
    while (tx !== 1'b0 && waited < 4 * FRAME_CYC)
    begin
      @(negedge clk);
      waited++;
    end
    fall_cyc = cyc;
    if (tx !== 1'b0)
      report_failure("timeout: no start bit appeared on tx");
    else
    begin
      repeat (BIT_CYC / 2) @(negedge clk);
      check_flag("tx_start", tx, 1'b0);
      for (i = 0; i < 8; i++)
      begin
        repeat (BIT_CYC) @(negedge clk);
        data[i] = tx;  // lsb first
      end
      repeat (BIT_CYC) @(negedge clk);
      par = tx;
      repeat (BIT_CYC) @(negedge clk);
      stop = tx;
    end
  endtask

  task automatic check_frame_shape(input uart_cmd_pkg::byte_t data, input logic par,
                                   input logic stop);
    check_flag("tx_parity", ^{data, par}, 1'b0);  // ones count even
    check_flag("tx_stop", stop, 1'b1);
  endtask

  // leaves rx high at the start of the stop bit
  task automatic send_frame(input uart_cmd_pkg::byte_t b, input bit flip_par);
    int i;
    @(posedge clk);
    rx <= 1'b0;
    for (i = 0; i < 8; i++)
    begin
      repeat (BIT_CYC) @(posedge clk);
      rx <= b[i];
    end
    repeat (BIT_CYC) @(posedge clk);
    rx <= ^b ^ flip_par;
    repeat (BIT_CYC) @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (cmd_rdy !== 1'b1 && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    if (cmd_rdy !== 1'b1)
      report_failure("timeout: cmd_rdy did not return high");
  endtask

  task automatic wait_read_rdy(input int limit, output bit seen);
    int waited;
    bit tx_low;
    waited = 0;
    tx_low = 1'b0;
    @(negedge clk);
    while (read_rdy !== 1'b1 && waited < limit)
    begin
      if (tx !== 1'b1)
        tx_low = 1'b1;
      @(negedge clk);
      waited++;
    end
    seen = (read_rdy === 1'b1);
    if (!seen)
      report_failure("timeout: read_rdy never pulsed");
    if (tx_low)
      report_failure("tx left idle while the read waited for its reply");
  endtask

  task automatic issue_cmd(input uart_cmd_pkg::cmd_t c);
    wait_cmd_rdy(FRAME_CYC);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_flag("tx", tx, 1'b1);
    check_flag("cmd_rdy", cmd_rdy, 1'b1);
    check_flag("read_rdy", read_rdy, 1'b0);
    check_flag("read_err", read_err, 1'b0);
    check_byte("read_data", read_data, 8'h00);
  endtask

  task automatic test_write(input uart_cmd_pkg::cmd_t c, input bit poke);
    uart_cmd_pkg::byte_t hi;
    uart_cmd_pkg::byte_t lo;
    logic                p;
    logic                s;
    int                  f_hi;
    int                  f_lo;
    int                  pulses0;
    int                  i;
    pulses0 = rdy_pulses;
    issue_cmd(c);
    recv_frame(hi, p, s, f_hi);
    check_frame_shape(hi, p, s);
    if (poke)
    begin
      @(posedge clk);
      cmd_in  <= ~c;  // ignored while the controller is busy
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    recv_frame(lo, p, s, f_lo);
    check_frame_shape(lo, p, s);
    check_cmd("tx_frames", {hi, lo}, c);
    checks++;
    if (f_lo - f_hi - FRAME_CYC < uart_cmd_pkg::FRAME_GAP)
      report_failure($sformatf("write frames only %0d idle cycles apart",
                               f_lo - f_hi - FRAME_CYC));
    wait_cmd_rdy(2 * BIT_CYC);
    check_flag("cmd_rdy", cmd_rdy, 1'b1);
    if (poke)
    begin
      for (i = 0; i < FRAME_CYC; i++)
      begin
        @(negedge clk);
        if (tx !== 1'b1)
          report_failure("extra frame on tx after an ignored command");
      end
    end
    if (rdy_pulses != pulses0)
      report_failure("read_rdy pulsed during a write");
  endtask

  // mode 0 good reply, 1 flipped parity, 2 no reply
  task automatic test_read(input uart_cmd_pkg::cmd_t c, input int mode);
    uart_cmd_pkg::byte_t hi;
    uart_cmd_pkg::byte_t reply;
    logic                p;
    logic                s;
    int                  f_hi;
    int                  pulses0;
    bit                  seen;
    pulses0 = rdy_pulses;
    reply = uart_cmd_pkg::byte_t'($random(seed));
    issue_cmd(c);
    recv_frame(hi, p, s, f_hi);
    check_frame_shape(hi, p, s);
    check_byte("tx_read_hi", hi, c[15:8]);
    if (mode != 2)
    begin
      repeat (BIT_CYC) @(posedge clk);
      send_frame(reply, mode == 1);
      wait_read_rdy(FRAME_CYC, seen);
    end
    else
      wait_read_rdy(uart_cmd_pkg::REPLY_TIMEOUT + 12 * BIT_CYC, seen);
    if (seen)
    begin
      if (mode == 0)
        check_byte("read_data", read_data, reply);
      if (mode == 2)
        check_byte("read_data", read_data, 8'h00);
      check_flag("read_err", read_err, mode != 0);
      @(negedge clk);
      check_flag("cmd_rdy", cmd_rdy, 1'b1);
      if (rdy_pulses != pulses0 + 1)
        report_failure("read_rdy did not pulse exactly once");
    end
  endtask

  initial
  begin
    uart_cmd_pkg::cmd_t c;
    int                 k;
    seed    = 89;
    errors  = 0;
    checks  = 0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    test_write(16'hA53C, 1'b0);
    test_read(16'h4212, 0);
    test_read(16'h1F80, 1);
    test_read(16'h3C5A, 0);  // clears read_err before the timeout case
    test_read(16'h7E01, 2);
    test_write(16'hC3A1, 1'b1);
    for (k = 0; k < 4; k++)
    begin
      c = uart_cmd_pkg::cmd_t'($random(seed));
      if (c[15])
        test_write(c, 1'b0);
      else
        test_read(c, 0);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- build.f
design/uart_cmd_pkg.sv
design/uart_byte_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_top.sv
tb/tb_uart_cmd_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_uart_cmd_top -f build.f

./obj_dir/Vtb_uart_cmd_top | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
